// ==== src/lc3b_types.sv ====
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [8:0] lc3b_c_tag;
	typedef logic [2:0] lc3b_c_index;
	typedef logic [3:0] lc3b_c_offset;

	// word 0 sits in the low bits of a line
	typedef logic [127:0] lc3b_cache_line;

	// bit 0 enables the low byte, bit 1 the high byte
	typedef logic [1:0] lc3b_mem_wmask;

	localparam int cache_ways = 2;
	localparam int cache_sets = 2 ** $bits(lc3b_c_index);

	// the same 16 bits seen either as a plain word or split for lookup
	typedef union packed {
		lc3b_word word;
		struct packed {
			lc3b_c_tag tag;
			lc3b_c_index index;
			lc3b_c_offset offset;
		} fields;
	} lc3b_addr;

	typedef struct packed {
		logic read;
		logic write;
		lc3b_addr address;
		lc3b_word wdata;
		lc3b_mem_wmask wmask;
	} lc3b_cpu_req;

	typedef struct packed {
		logic fill;
		logic wr_hit;
		logic lru_update;
		logic addr_sel_victim;
	} lc3b_cache_ctrl;

	typedef struct packed {
		logic hit;
		logic victim_dirty;
	} lc3b_cache_status;

endpackage : lc3b_types

// ==== src/cache_array.sv ====
module cache_array #(
	parameter int width = 1
) (
	input logic clk,
	input logic arst_n,
	input logic write,
	input lc3b_types::lc3b_c_index index,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);
	import lc3b_types::*;

	logic [width-1:0] entries [cache_sets];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < cache_sets; i++) begin
				entries[i] <= '0;
			end
		end else if (write) begin
			entries[index] <= datain;
		end
	end

	// read is combinational so lookup completes in the same cycle
	assign dataout = entries[index];

endmodule : cache_array

// ==== src/cache_datapath.sv ====
module cache_datapath (
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_cpu_req req,
	input lc3b_types::lc3b_cache_ctrl ctrl,
	input lc3b_types::lc3b_cache_line pmem_rdata,
	output lc3b_types::lc3b_cache_status status,
	output lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_cache_line pmem_wdata
);
	import lc3b_types::*;

	localparam int word_width = $bits(lc3b_word);
	localparam int line_width = $bits(lc3b_cache_line);
	localparam int tag_width = $bits(lc3b_c_tag);
	localparam int line_words = line_width / word_width;

	lc3b_c_tag tag;
	lc3b_c_index index;
	logic [$clog2(line_words)-1:0] word_sel;

	logic [cache_ways-1:0] valid_out;
	logic [cache_ways-1:0] dirty_out;
	logic [cache_ways-1:0] hit_way;
	logic [cache_ways-1:0] fill_way;
	logic [cache_ways-1:0] data_write;
	lc3b_c_tag tag_out [cache_ways];
	lc3b_cache_line data_out [cache_ways];

	logic hit;
	logic lru_out;
	logic sel_way;
	lc3b_cache_line sel_line;
	lc3b_cache_line merged_line;
	lc3b_cache_line data_in;
	lc3b_addr line_addr;

	assign tag = req.address.fields.tag;
	assign index = req.address.fields.index;
	// byte offset bit 0 is ignored since accesses are word aligned
	assign word_sel = req.address.fields.offset[3:1];

	for (genvar w = 0; w < cache_ways; w++) begin : g_way
		assign hit_way[w] = valid_out[w] && (tag_out[w] == tag);
		// a fill always lands in the LRU way
		assign fill_way[w] = ctrl.fill && (lru_out == 1'(w));
		assign data_write[w] = fill_way[w] || (ctrl.wr_hit && hit_way[w]);

		cache_array #(
			.width(1)
		) valid_array (
			.clk(clk),
			.arst_n(arst_n),
			.write(fill_way[w]),
			.index(index),
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		// fill cleans the line, a write hit marks it dirty
		cache_array #(
			.width(1)
		) dirty_array (
			.clk(clk),
			.arst_n(arst_n),
			.write(data_write[w]),
			.index(index),
			.datain(ctrl.wr_hit),
			.dataout(dirty_out[w])
		);

		cache_array #(
			.width(tag_width)
		) tag_array (
			.clk(clk),
			.arst_n(arst_n),
			.write(fill_way[w]),
			.index(index),
			.datain(tag),
			.dataout(tag_out[w])
		);

		cache_array #(
			.width(line_width)
		) data_array (
			.clk(clk),
			.arst_n(arst_n),
			.write(data_write[w]),
			.index(index),
			.datain(data_in),
			.dataout(data_out[w])
		);
	end

	// lru holds the way to replace next, so point it away from the way just used
	cache_array #(
		.width(1)
	) lru_array (
		.clk(clk),
		.arst_n(arst_n),
		.write(ctrl.lru_update),
		.index(index),
		.datain(~sel_way),
		.dataout(lru_out)
	);

	assign hit = |hit_way;
	assign sel_way = hit ? hit_way[1] : lru_out;
	assign sel_line = data_out[sel_way];

	assign mem_rdata = sel_line[word_sel * word_width +: word_width];

	always_comb begin
		merged_line = sel_line;
		if (req.wmask[0]) begin
			merged_line[word_sel * word_width +: 8] = req.wdata[7:0];
		end
		if (req.wmask[1]) begin
			merged_line[word_sel * word_width + 8 +: 8] = req.wdata[15:8];
		end
	end

	assign data_in = ctrl.fill ? pmem_rdata : merged_line;

	assign status = '{
		hit: hit,
		victim_dirty: valid_out[lru_out] && dirty_out[lru_out]
	};

	// memory only sees line aligned addresses
	always_comb begin
		line_addr = req.address;
		line_addr.fields.offset = '0;
		if (ctrl.addr_sel_victim) begin
			line_addr.fields.tag = tag_out[lru_out];
		end
	end

	assign pmem_address = line_addr.word;
	assign pmem_wdata = data_out[lru_out];

endmodule : cache_datapath

// ==== src/cache_control.sv ====
module cache_control (
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_cpu_req req,
	input lc3b_types::lc3b_cache_status status,
	input logic pmem_resp,
	output lc3b_types::lc3b_cache_ctrl ctrl,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write
);
	import lc3b_types::*;

	typedef enum logic [1:0] {
		compare,
		write_back,
		allocate
	} state_e;

	state_e state;
	state_e next_state;
	logic req_valid;

	assign req_valid = req.read || req.write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= compare;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			compare: begin
				// a miss needs the victim written out first if it holds modified data
				if (req_valid && !status.hit) begin
					if (status.victim_dirty) begin
						next_state = write_back;
					end else begin
						next_state = allocate;
					end
				end
			end
			write_back: begin
				if (pmem_resp) begin
					next_state = allocate;
				end
			end
			allocate: begin
				if (pmem_resp) begin
					next_state = compare;
				end
			end
			default: begin
				next_state = compare;
			end
		endcase
	end

	always_comb begin
		ctrl = '0;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		case (state)
			compare: begin
				if (req_valid && status.hit) begin
					mem_resp = 1'b1;
					ctrl.lru_update = 1'b1;
					ctrl.wr_hit = req.write;
				end
			end
			write_back: begin
				// the victim's own tag forms the write address
				pmem_write = 1'b1;
				ctrl.addr_sel_victim = 1'b1;
			end
			allocate: begin
				pmem_read = 1'b1;
				// the line is taken in the cycle memory answers
				ctrl.fill = pmem_resp;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule : cache_control

// ==== src/lc3b_cache.sv ====
module lc3b_cache (
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_cpu_req req,
	output lc3b_types::lc3b_word mem_rdata,
	output logic mem_resp,
	input lc3b_types::lc3b_cache_line pmem_rdata,
	input logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_cache_line pmem_wdata
);
	import lc3b_types::*;

	lc3b_cache_ctrl ctrl;
	lc3b_cache_status status;

	cache_control control_i (
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.status(status),
		.pmem_resp(pmem_resp),
		.ctrl(ctrl),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	cache_datapath datapath_i (
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.ctrl(ctrl),
		.pmem_rdata(pmem_rdata),
		.status(status),
		.mem_rdata(mem_rdata),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

endmodule : lc3b_cache

// ==== dv/clk_gen.sv ====
module clk_gen #(
	parameter int period = 20,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic arst_n
);
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// reset is released on a falling edge, away from the active edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule : clk_gen

// ==== dv/pmem_model.sv ====
module pmem_model #(
	parameter int latency = 4,
	parameter logic [15:0] pattern = 16'h0000
) (
	input logic clk,
	input logic arst_n,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_types::lc3b_word pmem_address,
	input lc3b_types::lc3b_cache_line pmem_wdata,
	output lc3b_types::lc3b_cache_line pmem_rdata,
	output logic pmem_resp
);
	import lc3b_types::*;

	localparam int lines = 4096;

	lc3b_cache_line mem [lines];
	logic [11:0] line_sel;
	int wait_count;

	// every word starts as its own word address mixed with the pattern
	initial begin
		for (int l = 0; l < lines; l++) begin
			for (int w = 0; w < 8; w++) begin
				mem[l][w * 16 +: 16] = {1'b0, 12'(l), 3'(w)} ^ pattern;
			end
		end
	end

	assign line_sel = pmem_address[15:4];
	assign pmem_rdata = mem[line_sel];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wait_count <= 0;
			pmem_resp <= 1'b0;
		end else if (pmem_resp) begin
			pmem_resp <= 1'b0;
		end else if (pmem_read || pmem_write) begin
			if (wait_count == latency - 1) begin
				wait_count <= 0;
				pmem_resp <= 1'b1;
			end else begin
				wait_count <= wait_count + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (pmem_resp && pmem_write)
			mem[line_sel] = pmem_wdata;
	end

endmodule : pmem_model

// ==== dv/lc3b_cache_sva.sv ====
module lc3b_cache_sva (
	input logic clk,
	input logic arst_n,
	input lc3b_types::lc3b_cpu_req req,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_types::lc3b_word pmem_address
);
	read_write_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write are high together");

	resp_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |-> (req.read || req.write))
		else $error("mem_resp without a read or write request");

	resp_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |=> !mem_resp)
		else $error("mem_resp lasted more than one cycle");

	// memory only ever moves whole lines
	line_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		(pmem_read || pmem_write) |-> (pmem_address[3:0] == 4'h0))
		else $error("pmem_address is not line aligned");

endmodule : lc3b_cache_sva

bind lc3b_cache lc3b_cache_sva lc3b_cache_sva_i (
	.clk(clk),
	.arst_n(arst_n),
	.req(req),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_address(pmem_address)
);

// ==== dv/lc3b_cache_tb.sv ====
module lc3b_cache_tb;
	import lc3b_types::*;

	localparam logic [15:0] fill_pattern = 16'hc35a;
	localparam int reset_cycles = 8;
	localparam int cycles_per_op = 40;
	localparam int random_ops = 400;
	// cold reads, byte masks, dirty eviction, clean eviction, then random traffic
	localparam int total_ops = 64 + 11 + 4 + 4 + random_ops;

	logic clk;
	logic arst_n;
	lc3b_cpu_req req;
	lc3b_word mem_rdata;
	logic mem_resp;
	lc3b_cache_line pmem_rdata;
	logic pmem_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_cache_line pmem_wdata;

	lc3b_word shadow [32768];
	int writeback_count = 0;
	int fill_count = 0;
	lc3b_word last_wb_address = '0;

	clk_gen #(
		.period(20),
		.reset_cycles(reset_cycles)
	) clk_gen_i (
		.clk(clk),
		.arst_n(arst_n)
	);

	pmem_model #(
		.latency(4),
		.pattern(fill_pattern)
	) pmem_model_i (
		.clk(clk),
		.arst_n(arst_n),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

	lc3b_cache lc3b_cache_i (
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.mem_rdata(mem_rdata),
		.mem_resp(mem_resp),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(string name, int got, int expected);
		assert (got == expected) else begin
			$display("** Error at time %0t: %s = %0h, expected %0h", $time, name, got, expected);
			abort_run();
		end
	endtask

	function automatic lc3b_word make_addr(lc3b_c_tag tag, lc3b_c_index index,
			lc3b_c_offset offset);
		lc3b_addr a;
		a.fields.tag = tag;
		a.fields.index = index;
		a.fields.offset = offset;
		return a.word;
	endfunction

	// a write merges its enabled bytes into the shadow, a read returns the shadow word
	function automatic lc3b_word shadow_access(lc3b_cpu_req r);
		lc3b_word w;
		w = shadow[r.address.word[15:1]];
		if (r.write) begin
			if (r.wmask[0])
				w[7:0] = r.wdata[7:0];
			if (r.wmask[1])
				w[15:8] = r.wdata[15:8];
			shadow[r.address.word[15:1]] = w;
		end
		return w;
	endfunction

	task automatic cpu_access(logic is_write, lc3b_word addr, lc3b_word data,
			lc3b_mem_wmask mask);
		req.read = !is_write;
		req.write = is_write;
		req.address.word = addr;
		req.wdata = data;
		req.wmask = is_write ? mask : 2'b00;
		do begin
			@(posedge clk);
		end while (!mem_resp);
		// an idle cycle keeps two responses from running together
		@(negedge clk);
		req = '0;
		@(negedge clk);
	endtask

	always @(posedge clk) begin
		lc3b_word expected;
		if (mem_resp) begin
			expected = shadow_access(req);
			if (req.read) begin
				assert (mem_rdata == expected) else begin
					$display("** Error at time %0t: mem_rdata = %h, expected %h (address %h)",
						$time, mem_rdata, expected, req.address.word);
					abort_run();
				end
			end
		end
		if (pmem_resp && pmem_read)
			fill_count++;
		if (pmem_resp && pmem_write) begin
			writeback_count++;
			last_wb_address = pmem_address;
			for (int w = 0; w < 8; w++) begin
				expected = shadow[{pmem_address[15:4], 3'(w)}];
				assert (pmem_wdata[w * 16 +: 16] == expected) else begin
					$display("** Error at time %0t: pmem_wdata word %0d = %h, expected %h",
						$time, w, pmem_wdata[w * 16 +: 16], expected);
					abort_run();
				end
			end
		end
	end

	initial begin
		repeat (reset_cycles + cycles_per_op * total_ops) @(posedge clk);
		$display("timeout: the cache stopped answering requests");
		abort_run();
	end

	initial begin
		int fills;
		int writebacks;
		logic [31:0] rnd;
		void'($urandom(32'hdce));
		req = '0;
		for (int a = 0; a < 32768; a++)
			shadow[a] = 16'(a) ^ fill_pattern;
		@(posedge arst_n);
		@(negedge clk);

		// each set fills once on its first word and hits on the rest of the line
		for (int s = 0; s < 8; s++) begin
			fills = fill_count;
			for (int w = 0; w < 8; w++)
				cpu_access(1'b0, make_addr(9'h010, s[2:0], {w[2:0], 1'b0}), '0, 2'b00);
			check_value("fill_count", fill_count - fills, 1);
		end

		cpu_access(1'b1, make_addr(9'h020, 3'd3, 4'h2), 16'($urandom), 2'b01);
		cpu_access(1'b1, make_addr(9'h020, 3'd3, 4'h4), 16'($urandom), 2'b10);
		cpu_access(1'b1, make_addr(9'h020, 3'd3, 4'h6), 16'($urandom), 2'b11);
		for (int w = 0; w < 8; w++)
			cpu_access(1'b0, make_addr(9'h020, 3'd3, {w[2:0], 1'b0}), '0, 2'b00);

		// the third tag on set 5 evicts the dirty line of the first
		writebacks = writeback_count;
		cpu_access(1'b1, make_addr(9'h030, 3'd5, 4'h8), 16'($urandom), 2'b11);
		cpu_access(1'b0, make_addr(9'h031, 3'd5, 4'h0), '0, 2'b00);
		cpu_access(1'b0, make_addr(9'h032, 3'd5, 4'h0), '0, 2'b00);
		check_value("writeback_count", writeback_count - writebacks, 1);
		check_value("last_wb_address", int'(last_wb_address),
			int'(make_addr(9'h030, 3'd5, 4'h0)));
		cpu_access(1'b0, make_addr(9'h030, 3'd5, 4'h8), '0, 2'b00);
		check_value("writeback_count", writeback_count - writebacks, 1);

		// lines that were only read are dropped without a write-back
		writebacks = writeback_count;
		cpu_access(1'b0, make_addr(9'h040, 3'd6, 4'h0), '0, 2'b00);
		cpu_access(1'b0, make_addr(9'h041, 3'd6, 4'h0), '0, 2'b00);
		cpu_access(1'b0, make_addr(9'h042, 3'd6, 4'h0), '0, 2'b00);
		cpu_access(1'b0, make_addr(9'h040, 3'd6, 4'h0), '0, 2'b00);
		check_value("writeback_count", writeback_count - writebacks, 0);

		// four tags per set keep conflicts frequent
		for (int i = 0; i < random_ops; i++) begin
			rnd = $urandom;
			cpu_access(rnd[0], make_addr(9'h050 + {7'd0, rnd[2:1]}, rnd[5:3], {rnd[8:6], 1'b0}),
				rnd[31:16], (rnd[10:9] == 2'b00) ? 2'b11 : rnd[10:9]);
		end

		$display("Test passed");
		$finish;
	end

endmodule : lc3b_cache_tb

// ==== lc3b_cache.f ====
src/lc3b_types.sv
src/cache_array.sv
src/cache_datapath.sv
src/cache_control.sv
src/lc3b_cache.sv
dv/clk_gen.sv
dv/pmem_model.sv
dv/lc3b_cache_sva.sv
dv/lc3b_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -f lc3b_cache.f --top-module lc3b_cache_tb -o lc3b_cache_sim &&
	./obj_dir/lc3b_cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
